//--- Makefile
TOP = tb_chiplet_switch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

# pass only when the pass message shows up in the output
sim:
	verilator --binary -j 0 -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- design/chiplet_switch.sv
`timescale 1ns/1ps
`default_nettype none

module chiplet_switch #(
    parameter chiplet_types_pkg::node_id_t NODE = '0
) (
    input  logic                                           clk,
    input  logic                                           n_rst,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]        in_valid,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        in_ready,
    input  chiplet_types_pkg::flit_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        in_flit,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        out_valid,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]        out_ready,
    output chiplet_types_pkg::flit_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        out_flit,
    output logic [chiplet_types_pkg::COUNT_W-1:0]          drop_count
);
    import chiplet_types_pkg::*;

    logic [NUM_PORTS-1:0]                    head_valid;
    flit_t [NUM_PORTS-1:0]                   head_flit;
    logic [NUM_PORTS-1:0]                    fwd_pop;
    logic [NUM_PORTS-1:0]                    drop_pop;
    logic [NUM_PORTS-1:0]                    fifo_pop;
    logic [NUM_PORTS-1:0]                    drop_event;
    logic [NUM_PORTS-1:0][TABLE_ADDR_W-1:0]  rd_addr;
    logic [NUM_PORTS-1:0]                    rd_hit;
    port_sel_t [NUM_PORTS-1:0]               rd_sel;
    cfg_wr_t                                 cfg_wr;
    route_dec_t [NUM_PORTS-1:0]              dec;
    logic [COUNT_W:0]                        drop_sum;

    // forwarded and consumed pops are disjoint
    assign fifo_pop = fwd_pop | drop_pop;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        flit_fifo u_fifo (
            .clk        (clk),
            .n_rst      (n_rst),
            .wr_valid   (in_valid[p]),
            .wr_ready   (in_ready[p]),
            .wr_flit    (in_flit[p]),
            .pop        (fifo_pop[p]),
            .head_valid (head_valid[p]),
            .head_flit  (head_flit[p])
        );
    end

    route_table u_table (
        .clk     (clk),
        .n_rst   (n_rst),
        .wr      (cfg_wr),
        .rd_addr (rd_addr),
        .rd_hit  (rd_hit),
        .rd_sel  (rd_sel)
    );

    route_compute #(.NODE(NODE)) u_route (
        .clk        (clk),
        .n_rst      (n_rst),
        .head_valid (head_valid),
        .head_flit  (head_flit),
        .pop        (fwd_pop),
        .rd_addr    (rd_addr),
        .rd_hit     (rd_hit),
        .rd_sel     (rd_sel),
        .cfg_wr     (cfg_wr),
        .dec        (dec),
        .drop_pop   (drop_pop),
        .drop_event (drop_event)
    );

    output_stage u_out (
        .clk       (clk),
        .n_rst     (n_rst),
        .dec       (dec),
        .head_flit (head_flit),
        .out_ready (out_ready),
        .pop       (fwd_pop),
        .out_valid (out_valid),
        .out_flit  (out_flit)
    );

    // up to one drop per input each cycle
    assign drop_sum = {1'b0, drop_count} + (COUNT_W + 1)'($countones(drop_event));

    // saturating drop counter
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            drop_count <= '0;
        end else if (drop_sum[COUNT_W]) begin
            drop_count <= '1;
        end else begin
            drop_count <= drop_sum[COUNT_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- design/chiplet_types_pkg.sv
`default_nettype none

package chiplet_types_pkg;

    // switch geometry with port 0 as the local port
    localparam int NUM_PORTS = 4;
    localparam int PORT_W = 2;

    // node ids
    localparam int NODE_W = 5;

    // route table indexed by low bits of source and destination
    localparam int TABLE_NODE_W = 3;
    localparam int TABLE_ADDR_W = 2 * TABLE_NODE_W;
    localparam int TABLE_DEPTH = 1 << TABLE_ADDR_W;

    // input buffering with a power of two depth
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // saturating drop counter
    localparam int COUNT_W = 16;

    typedef logic [NODE_W-1:0] node_id_t;
    typedef logic [PORT_W-1:0] port_sel_t;

    typedef enum logic [3:0] {
        FMT_DATA       = 4'h0,
        FMT_SWITCH_CFG = 4'h1
    } format_e;

    // single head flit
    // payload 31:28 format, 27:23 dest, 22:17 cfg addr, 1:0 cfg out_sel
    typedef struct packed {
        node_id_t    req;
        logic [31:0] payload;
    } flit_t;

    // registered per-input routing decision
    typedef struct packed {
        logic      valid;
        logic      drop;
        port_sel_t out_sel;
    } route_dec_t;

    // route table write
    typedef struct packed {
        logic                    en;
        logic [TABLE_ADDR_W-1:0] addr;
        port_sel_t               out_sel;
    } cfg_wr_t;

    function automatic format_e flit_format(flit_t f);
        return format_e'(f.payload[31:28]);
    endfunction

    function automatic node_id_t flit_dest(flit_t f);
        return f.payload[27:23];
    endfunction

    function automatic logic [TABLE_ADDR_W-1:0] flit_cfg_addr(flit_t f);
        return f.payload[22:17];
    endfunction

    function automatic port_sel_t flit_cfg_sel(flit_t f);
        return f.payload[1:0];
    endfunction

    // table index is {req low bits, dest low bits}
    function automatic logic [TABLE_ADDR_W-1:0] table_index(flit_t f);
        node_id_t dest;
        dest = flit_dest(f);
        return {f.req[TABLE_NODE_W-1:0], dest[TABLE_NODE_W-1:0]};
    endfunction

endpackage

`default_nettype wire

//--- design/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_fifo (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  chiplet_types_pkg::flit_t wr_flit,
    input  logic                     pop,
    output logic                     head_valid,
    output chiplet_types_pkg::flit_t head_flit
);
    import chiplet_types_pkg::*;

    // storage
    flit_t mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;

    // ready drops only when full
    assign wr_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign push = wr_valid && wr_ready;

    // show-ahead head straight from the array
    assign head_valid = (count != '0);
    assign head_flit = mem[rd_ptr];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap naturally
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    // pop comes from route compute or the output stage
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!n_rst)
        pop |-> head_valid)
        else $error("flit_fifo: pop while empty");

endmodule

`default_nettype wire

//--- design/output_stage.sv
`timescale 1ns/1ps
`default_nettype none

module output_stage (
    input  logic                                           clk,
    input  logic                                           n_rst,
    input  chiplet_types_pkg::route_dec_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        dec,
    input  chiplet_types_pkg::flit_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        head_flit,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]        out_ready,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        pop,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        out_valid,
    output chiplet_types_pkg::flit_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        out_flit
);
    import chiplet_types_pkg::*;

    // req[o][i], grant[o][i], indexed output first
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;
    // transposed, grant_by_in[i][o]
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_by_in;
    port_sel_t [NUM_PORTS-1:0]           win;
    port_sel_t [NUM_PORTS-1:0]           rr_q;
    logic [NUM_PORTS-1:0]                load;

    // register free or draining this cycle
    assign load = ~out_valid | out_ready;

    // requests from valid forwarded decisions
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req[o][i] = dec[i].valid && !dec[i].drop &&
                            (dec[i].out_sel == port_sel_t'(o));
            end
        end
    end

    // round-robin search starting at the pointer
    always_comb begin
        port_sel_t idx;
        grant = '0;
        win = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int k = 0; k < NUM_PORTS; k++) begin
                idx = rr_q[o] + port_sel_t'(k);
                if (load[o] && req[o][idx] && (grant[o] == '0)) begin
                    grant[o][idx] = 1'b1;
                    win[o] = idx;
                end
            end
        end
    end

    // winner pops its FIFO
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                grant_by_in[i][o] = grant[o][i];
            end
            pop[i] = |grant_by_in[i];
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            out_valid <= '0;
            rr_q      <= '0;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (load[o]) begin
                    out_valid[o] <= |grant[o];
                end
                // pointer moves one past the winner
                if (|grant[o]) begin
                    rr_q[o] <= win[o] + port_sel_t'(1);
                end
            end
        end
    end

    // crossbar into the holding registers
    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (|grant[o]) begin
                out_flit[o] <= head_flit[win[o]];
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_chk
        a_grant_onehot: assert property (@(posedge clk) disable iff (!n_rst)
            $onehot0(grant[o]))
            else $error("output_stage: multiple grants on one output");
        a_input_once: assert property (@(posedge clk) disable iff (!n_rst)
            $onehot0(grant_by_in[o]))
            else $error("output_stage: input granted by two outputs");
        // stall holds the flit
        a_hold: assert property (@(posedge clk) disable iff (!n_rst)
            out_valid[o] && !out_ready[o] |=> out_valid[o] && $stable(out_flit[o]))
            else $error("output_stage: output changed while stalled");
    end

endmodule

`default_nettype wire

//--- design/route_compute.sv
`timescale 1ns/1ps
`default_nettype none

module route_compute #(
    parameter chiplet_types_pkg::node_id_t NODE = '0
) (
    input  logic                                           clk,
    input  logic                                           n_rst,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]        head_valid,
    input  chiplet_types_pkg::flit_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        head_flit,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]        pop,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]
                 [chiplet_types_pkg::TABLE_ADDR_W-1:0]     rd_addr,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]        rd_hit,
    input  chiplet_types_pkg::port_sel_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        rd_sel,
    output chiplet_types_pkg::cfg_wr_t                     cfg_wr,
    output chiplet_types_pkg::route_dec_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        dec,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        drop_pop,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        drop_event
);
    import chiplet_types_pkg::*;

    route_dec_t [NUM_PORTS-1:0] next_dec;
    logic [NUM_PORTS-1:0]       is_cfg;
    // decided flit is a config packet for this node
    logic [NUM_PORTS-1:0]       cfg_q;
    logic [NUM_PORTS-1:0]       cfg_grant;
    logic                       cfg_found;

    // decode every head in parallel
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            rd_addr[i] = table_index(head_flit[i]);
            is_cfg[i] = (flit_format(head_flit[i]) == FMT_SWITCH_CFG) &&
                        (flit_dest(head_flit[i]) == NODE);
            next_dec[i] = '0;
            next_dec[i].valid = 1'b1;
            if (is_cfg[i]) begin
                // consumed here, never reaches an output
                next_dec[i].drop = 1'b1;
            end else if (flit_dest(head_flit[i]) == NODE) begin
                // local delivery on port 0
                next_dec[i].out_sel = '0;
            end else if (rd_hit[i]) begin
                next_dec[i].out_sel = rd_sel[i];
            end else begin
                // table miss
                next_dec[i].drop = 1'b1;
            end
        end
    end

    // decision register, held until the flit leaves
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            dec   <= '0;
            cfg_q <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (pop[i] || drop_pop[i]) begin
                    dec[i]   <= '0;
                    cfg_q[i] <= 1'b0;
                end else if (head_valid[i] && !dec[i].valid) begin
                    dec[i]   <= next_dec[i];
                    cfg_q[i] <= is_cfg[i];
                end
            end
        end
    end

    // single table write port, lowest index first
    always_comb begin
        cfg_grant = '0;
        cfg_found = 1'b0;
        cfg_wr = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (dec[i].valid && cfg_q[i] && !cfg_found) begin
                cfg_found = 1'b1;
                cfg_grant[i] = 1'b1;
                cfg_wr.en = 1'b1;
                cfg_wr.addr = flit_cfg_addr(head_flit[i]);
                cfg_wr.out_sel = flit_cfg_sel(head_flit[i]);
            end
        end
    end

    // misses pop at once, config flits once they own the write port
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            drop_pop[i] = dec[i].valid && dec[i].drop && (!cfg_q[i] || cfg_grant[i]);
            drop_event[i] = dec[i].valid && dec[i].drop && !cfg_q[i];
        end
    end

    a_one_cfg_write: assert property (@(posedge clk) disable iff (!n_rst)
        $onehot0(cfg_grant))
        else $error("route_compute: more than one cfg write");

    // forwarded and consumed pops never hit the same flit
    a_pop_disjoint: assert property (@(posedge clk) disable iff (!n_rst)
        (pop & drop_pop) == '0)
        else $error("route_compute: flit popped twice");

endmodule

`default_nettype wire

//--- design/route_table.sv
`timescale 1ns/1ps
`default_nettype none

module route_table (
    input  logic                                           clk,
    input  logic                                           n_rst,
    input  chiplet_types_pkg::cfg_wr_t                     wr,
    input  logic [chiplet_types_pkg::NUM_PORTS-1:0]
                 [chiplet_types_pkg::TABLE_ADDR_W-1:0]     rd_addr,
    output logic [chiplet_types_pkg::NUM_PORTS-1:0]        rd_hit,
    output chiplet_types_pkg::port_sel_t
                 [chiplet_types_pkg::NUM_PORTS-1:0]        rd_sel
);
    import chiplet_types_pkg::*;

    // per-entry valid bits cleared on reset
    logic [TABLE_DEPTH-1:0] entry_valid;

    // per-entry output port
    port_sel_t entry_sel [TABLE_DEPTH];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            entry_valid <= '0;
        end else if (wr.en) begin
            // entries are only ever set, never invalidated
            entry_valid[wr.addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.en) begin
            entry_sel[wr.addr] <= wr.out_sel;
        end
    end

    // four independent lookups
    // rd_sel only meaningful with rd_hit
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_hit[p] = entry_valid[rd_addr[p]];
            rd_sel[p] = entry_sel[rd_addr[p]];
        end
    end

    // config writes carry a known address and port
    a_wr_known: assert property (@(posedge clk) disable iff (!n_rst)
        wr.en |-> !$isunknown({wr.addr, wr.out_sel}))
        else $error("route_table: unknown config write");

endmodule

`default_nettype wire

//--- flist.f
design/chiplet_types_pkg.sv
design/flit_fifo.sv
design/route_table.sv
design/route_compute.sv
design/output_stage.sv
design/chiplet_switch.sv
verif/tb_chiplet_switch.sv

//--- verif/tb_chiplet_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_chiplet_switch;
    import chiplet_types_pkg::*;

    localparam node_id_t NODE = 5;
    // reference results besides a port index
    localparam int DROPPED = -1;
    localparam int CONSUMED = -2;

    logic                         clk = 1'b0;
    logic                         n_rst = 1'b0;
    logic [NUM_PORTS-1:0]         in_valid = '0;
    logic [NUM_PORTS-1:0]         in_ready;
    flit_t [NUM_PORTS-1:0]        in_flit = '0;
    logic [NUM_PORTS-1:0]         out_valid;
    logic [NUM_PORTS-1:0]         out_ready = '1;
    flit_t [NUM_PORTS-1:0]        out_flit;
    logic [COUNT_W-1:0]           drop_count;

    // stimulus per input, expected flits per input and output pair
    flit_t send_q [NUM_PORTS][$];
    flit_t exp_q [NUM_PORTS][NUM_PORTS][$];
    // reference copy of the route table
    logic [TABLE_DEPTH-1:0] tbl_valid = '0;
    port_sel_t              tbl_sel [TABLE_DEPTH];
    logic [COUNT_W-1:0]     exp_drops = '0;
    int                     seq [NUM_PORTS];
    int                     flits_sent = 0;
    int                     wd_cycles = 0;
    logic [31:0]            lfsr_q = 32'd82689;
    logic                   bp_on = 1'b0;
    logic [NUM_PORTS-1:0]   held_v = '0;
    flit_t                  held_f [NUM_PORTS];
    string                  test_name = "reset";

    chiplet_switch #(.NODE(NODE)) u_dut (
        .clk        (clk),
        .n_rst      (n_rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_flit    (in_flit),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_flit   (out_flit),
        .drop_count (drop_count)
    );

    always #2 clk = ~clk;

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic flit_t make_flit(format_e fmt, node_id_t req, node_id_t dest,
                                        logic [TABLE_ADDR_W-1:0] addr, port_sel_t sel);
        flit_t f;
        f.req = req;
        f.payload = '0;
        f.payload[31:28] = fmt;
        f.payload[27:23] = dest;
        f.payload[22:17] = addr;
        f.payload[1:0] = sel;
        return f;
    endfunction

    // port for a flit under the current table, or drop / consumed
    function automatic int expected_port(flit_t f);
        logic [TABLE_ADDR_W-1:0] idx;
        idx = {f.req[2:0], f.payload[25:23]};
        if (format_e'(f.payload[31:28]) == FMT_SWITCH_CFG && f.payload[27:23] == NODE) begin
            return CONSUMED;
        end
        if (f.payload[27:23] == NODE) begin
            return 0;
        end
        if (tbl_valid[idx]) begin
            return int'(tbl_sel[idx]);
        end
        return DROPPED;
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare_flit(string name, flit_t exp, flit_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            report_failure("flit mismatch");
        end
    endtask

    task automatic compare_count(string name, logic [COUNT_W-1:0] exp, logic [COUNT_W-1:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            report_failure("drop counter mismatch");
        end
    endtask

    task automatic compare_ports(string name, logic [NUM_PORTS-1:0] exp,
                                 logic [NUM_PORTS-1:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            report_failure("port status mismatch");
        end
    endtask

    // tag with input and sequence, then book the expected result
    task automatic queue_flit(int p, flit_t f);
        flit_t g;
        int    dst;
        g = f;
        g.payload[15:4] = seq[p][11:0];
        g.payload[3:2] = p[1:0];
        seq[p]++;
        dst = expected_port(g);
        if (dst == CONSUMED) begin
            tbl_valid[g.payload[22:17]] = 1'b1;
            tbl_sel[g.payload[22:17]] = g.payload[1:0];
        end else if (dst == DROPPED) begin
            exp_drops++;
        end else begin
            exp_q[p][dst].push_back(g);
        end
        send_q[p].push_back(g);
        flits_sent++;
    endtask

    function automatic logic all_queues_empty();
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (send_q[i].size() != 0) begin
                return 1'b0;
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (exp_q[i][o].size() != 0) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // local marker on every input flushes everything queued before it
    task automatic finish_phase();
        for (int p = 0; p < NUM_PORTS; p++) begin
            queue_flit(p, make_flit(FMT_DATA, node_id_t'(p), NODE, '0, '0));
        end
        @(negedge clk);
        while (!(all_queues_empty() && in_valid == '0)) begin
            @(negedge clk);
        end
        compare_count(test_name, exp_drops, drop_count);
    endtask

    task automatic random_traffic(int n);
        node_id_t dest;
        node_id_t req;
        format_e  fmt;
        int       p;
        for (int k = 0; k < n; k++) begin
            dest = node_id_t'(take_bits(NODE_W));
            req = node_id_t'(take_bits(NODE_W));
            fmt = take_bits(1) ? FMT_SWITCH_CFG : FMT_DATA;
            p = int'(take_bits(PORT_W));
            // a cfg for this node would rewrite the table mid traffic
            if (dest == NODE) begin
                fmt = FMT_DATA;
            end
            queue_flit(p, make_flit(fmt, req, dest, '0, '0));
        end
    endtask

    // input driver, next flit once the current one is taken
    always @(posedge clk) begin
        flit_t nxt;
        if (n_rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!in_valid[p] || in_ready[p]) begin
                    if (send_q[p].size() > 0) begin
                        nxt = send_q[p].pop_front();
                        in_valid[p] <= 1'b1;
                        in_flit[p] <= nxt;
                    end else begin
                        in_valid[p] <= 1'b0;
                    end
                end
            end
        end
    end

    // random back-pressure when enabled
    always @(posedge clk) begin
        if (bp_on) begin
            out_ready <= NUM_PORTS'(take_bits(NUM_PORTS));
        end else begin
            out_ready <= '1;
        end
    end

    // scoreboard, input found from the payload tag
    always @(posedge clk) begin
        int src;
        if (n_rst) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (held_v[o] && !out_valid[o]) begin
                    report_failure($sformatf("output %0d lost valid while stalled", o));
                end else if (held_v[o]) begin
                    compare_flit("stall hold", held_f[o], out_flit[o]);
                end
                held_v[o] = out_valid[o] && !out_ready[o];
                held_f[o] = out_flit[o];
                if (out_valid[o] && out_ready[o]) begin
                    src = int'(out_flit[o].payload[3:2]);
                    if (exp_q[src][o].size() == 0) begin
                        report_failure($sformatf("unexpected flit on output %0d from input %0d",
                                                 o, src));
                    end else begin
                        compare_flit(test_name, exp_q[src][o].pop_front(), out_flit[o]);
                    end
                end
            end
        end
    end

    // limit grows with every flit queued
    initial begin
        while (wd_cycles <= 40 * flits_sent + 200) begin
            @(posedge clk);
            wd_cycles++;
        end
        report_failure("timeout, flits still in flight");
    end

    initial begin
        node_id_t req;
        node_id_t dest;
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        @(negedge clk);
        compare_ports("reset out_valid", '0, out_valid);
        compare_ports("reset in_ready", '1, in_ready);
        compare_count("reset drop_count", '0, drop_count);

        // local delivery from every input
        test_name = "local";
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < 6; k++) begin
                req = node_id_t'(take_bits(NODE_W));
                queue_flit(p, make_flit(FMT_DATA, req, NODE, '0, '0));
            end
        end
        finish_phase();

        // empty table, every remote flit misses
        test_name = "miss";
        for (int k = 0; k < 8; k++) begin
            dest = node_id_t'(take_bits(NODE_W));
            if (dest == NODE) begin
                dest = dest + 1'b1;
            end
            queue_flit(k % NUM_PORTS, make_flit(FMT_DATA, node_id_t'(k), dest, '0, '0));
        end
        finish_phase();

        // a few entries, one per input
        test_name = "config";
        for (int k = 0; k < NUM_PORTS; k++) begin
            queue_flit(k, make_flit(FMT_SWITCH_CFG, node_id_t'(k), NODE,
                                    TABLE_ADDR_W'(9 * k + 17), port_sel_t'(3 - k)));
        end
        finish_phase();
        test_name = "routed";
        for (int k = 0; k < NUM_PORTS; k++) begin
            req = {2'b00, 3'((9 * k + 17) >> 3)};
            dest = {2'b01, 3'(9 * k + 17)};
            queue_flit(k, make_flit(FMT_DATA, req, dest, '0, '0));
        end
        // cfg for another node goes through the table like data
        queue_flit(0, make_flit(FMT_SWITCH_CFG, 5'b11011, 5'b10010, '0, '0));
        finish_phase();

        // whole table, then random traffic
        test_name = "program all";
        for (int a = 0; a < TABLE_DEPTH; a++) begin
            queue_flit(a % NUM_PORTS, make_flit(FMT_SWITCH_CFG, node_id_t'(a), NODE,
                                                TABLE_ADDR_W'(a), port_sel_t'(take_bits(PORT_W))));
        end
        finish_phase();
        test_name = "random";
        random_traffic(200);
        finish_phase();

        test_name = "backpressure";
        bp_on = 1'b1;
        random_traffic(200);
        finish_phase();
        bp_on = 1'b0;

        if (all_queues_empty()) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_failure("scoreboard not empty at end of run");
        end
    end

endmodule

`default_nettype wire
